//--- clusterCompactor.sv
`timescale 1ns/10ps

module clusterCompactor import packerPkg::*; (
	input logic clock,
	input logic rstN,

	// Sparse blocks from the operand fetch
	input transferBlockT inBlock,
	input logic inValid,
	output logic inReady,

	// Compacted blocks to the residual buffer
	output compactBlockT compBlock,
	output logic compValid,
	input logic compReady
);

	countT [TRANSFER_SIZE-1:0] laneCount;
	compactBlockT compacted;

	// ==================================================
	// Prefix counts of the select mask
	// ==================================================

	maskAccumulator maskAccum (
		.selectMask(inBlock.selectMask),
		.laneCount(laneCount)
	);

	// ==================================================
	// Priority select filter
	// ==================================================
	// Output slot k takes the lane where the running count first
	// reaches k+1. Lanes are scanned from the top down and the last
	// hit wins, which gives the lowest such lane priority.
	// That lane is always a selected one

	always_comb begin
		for (int slot = 0; slot < TRANSFER_SIZE; slot++) begin
			compacted.clusters[slot] = '0;
			for (int lane = TRANSFER_SIZE - 1; lane >= 0; lane--) begin
				if (laneCount[lane] == countT'(slot + 1)) begin
					compacted.clusters[slot] = inBlock.clusters[lane];
				end
			end
		end

		// Total selected clusters in this block
		compacted.numValid = laneCount[TRANSFER_SIZE-1];
	end

	// ==================================================
	// Stage register
	// ==================================================

	// Room when empty or when the downstream stage takes the item
	assign inReady = !compValid || compReady;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			compValid <= 1'b0;
		end else if (inReady) begin
			compValid <= inValid;
		end
	end

	// Payload only moves on an accepted transfer
	always_ff @(posedge clock) begin
		if (inValid && inReady) begin
			compBlock <= compacted;
		end
	end

endmodule

//--- maskAccumulator.sv
`timescale 1ns/10ps

module maskAccumulator import packerPkg::*; (
	input logic [TRANSFER_SIZE-1:0] selectMask,
	output countT [TRANSFER_SIZE-1:0] laneCount
);

	// ==================================================
	// Running count of set select bits
	// ==================================================
	// Lane i sees the bits of lanes 0 .. i, counted from the LSB upward.
	// A count that already hit TRANSFER_SIZE wraps to zero before the
	// next bit is added, so a longer mask splits into windows

	always_comb begin
		countT previous;
		countT operandA;
		countT operandB;

		previous = '0;
		for (int lane = 0; lane < TRANSFER_SIZE; lane++) begin
			operandA = previous;
			// Cap the running count at one full block
			if (previous == countT'(TRANSFER_SIZE)) begin
				operandA = '0;
			end
			operandB = countT'(selectMask[lane]);
			laneCount[lane] = operandA + operandB;
			previous = laneCount[lane];
		end
	end

endmodule

//--- packerPkg.sv
package packerPkg;

	// ==================================================
	// Sizes
	// ==================================================

	// Clusters per input block and per MAC operand block
	localparam int TRANSFER_SIZE = 4;
	localparam int CLUSTER_WIDTH = 16;

	// Count of selected clusters, 0 up to TRANSFER_SIZE
	localparam int COUNT_WIDTH = 3;

	// Residual occupancy, never reaches TRANSFER_SIZE
	localparam int RESIDUAL_WIDTH = 2;

	// ==================================================
	// Types
	// ==================================================

	typedef logic [CLUSTER_WIDTH-1:0] clusterT;
	typedef logic [COUNT_WIDTH-1:0] countT;
	typedef logic [RESIDUAL_WIDTH-1:0] residualCountT;

	// Sparse input block, lane 0 sits in the low bits
	typedef struct packed {
		clusterT [TRANSFER_SIZE-1:0] clusters;
		logic [TRANSFER_SIZE-1:0] selectMask;
	} transferBlockT;

	// Selected clusters packed from slot 0, unused slots are zero
	typedef struct packed {
		clusterT [TRANSFER_SIZE-1:0] clusters;
		countT numValid;
	} compactBlockT;

	// Dense operand block for the MAC array
	typedef clusterT [TRANSFER_SIZE-1:0] macBlockT;

endpackage

//--- residualBuffer.sv
`timescale 1ns/10ps

module residualBuffer import packerPkg::*; (
	input logic clock,
	input logic rstN,

	// Compacted clusters from the first stage
	input compactBlockT compBlock,
	input logic compValid,
	output logic compReady,

	// Dense MAC operand blocks
	output macBlockT outBlock,
	output logic outValid,
	input logic outReady
);

	// Leftover clusters that did not fill a MAC block yet
	macBlockT residual;
	residualCountT residualSize;

	// Residual followed by the new clusters, two blocks wide
	clusterT [2*TRANSFER_SIZE-1:0] paddedResidual;
	clusterT [2*TRANSFER_SIZE-1:0] paddedComp;
	clusterT [2*TRANSFER_SIZE-1:0] concatenated;

	countT totalSize;
	logic blockFull;
	macBlockT nextResidual;
	residualCountT nextSize;
	logic compTransfer;

	// ==================================================
	// Buffer concatenation
	// ==================================================

	assign paddedResidual = {{(TRANSFER_SIZE * CLUSTER_WIDTH){1'b0}}, residual};
	assign paddedComp = {{(TRANSFER_SIZE * CLUSTER_WIDTH){1'b0}}, compBlock.clusters};

	// At most TRANSFER_SIZE-1 plus TRANSFER_SIZE, fits in a count
	assign totalSize = countT'(residualSize) + compBlock.numValid;

	always_comb begin
		for (int slot = 0; slot < 2 * TRANSFER_SIZE; slot++) begin
			if (slot < int'(residualSize)) begin
				concatenated[slot] = paddedResidual[slot];
			end else if (slot < int'(totalSize)) begin
				// New clusters start right after the residual ones
				concatenated[slot] = paddedComp[slot - int'(residualSize)];
			end else begin
				concatenated[slot] = '0;
			end
		end
	end

	// ==================================================
	// Residual update
	// ==================================================

	assign blockFull = totalSize >= countT'(TRANSFER_SIZE);

	// A full block leaves the upper half behind as the new residual
	assign nextResidual = blockFull ? concatenated[2*TRANSFER_SIZE-1:TRANSFER_SIZE]
		: concatenated[TRANSFER_SIZE-1:0];

	assign nextSize = blockFull ? residualCountT'(totalSize - countT'(TRANSFER_SIZE))
		: residualCountT'(totalSize);

	// ==================================================
	// Handshake and registers
	// ==================================================

	// Output register empty or being drained this cycle
	assign compReady = !outValid || outReady;
	assign compTransfer = compValid && compReady;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			residualSize <= '0;
			outValid <= 1'b0;
		end else begin
			if (compReady) begin
				// Only a block-completing item produces an output
				outValid <= compValid && blockFull;
			end
			if (compTransfer) begin
				residualSize <= nextSize;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (compTransfer) begin
			residual <= nextResidual;
			if (blockFull) begin
				outBlock <= concatenated[TRANSFER_SIZE-1:0];
			end
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the packer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module sparseClusterPackerTb \
	-f tb.f \
	-o simPacker

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/simPacker +verilator+error+limit+10000 2>&1 | tee "$LOG"

if grep -q "Checks failed" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- sparseClusterPacker.sv
`timescale 1ns/10ps

module sparseClusterPacker import packerPkg::*; (
	input logic clock,
	input logic rstN,

	// Sparse input blocks with select masks
	input transferBlockT inBlock,
	input logic inValid,
	output logic inReady,

	// Dense MAC operand blocks
	output macBlockT outBlock,
	output logic outValid,
	input logic outReady
);

	// Between the two pipeline stages
	compactBlockT compBlock;
	logic compValid;
	logic compReady;

	// ==================================================
	// Stage 1, compaction
	// ==================================================

	clusterCompactor compactor (
		.clock(clock),
		.rstN(rstN),
		.inBlock(inBlock),
		.inValid(inValid),
		.inReady(inReady),
		.compBlock(compBlock),
		.compValid(compValid),
		.compReady(compReady)
	);

	// ==================================================
	// Stage 2, residual merge and MAC block output
	// ==================================================

	residualBuffer buffer (
		.clock(clock),
		.rstN(rstN),
		.compBlock(compBlock),
		.compValid(compValid),
		.compReady(compReady),
		.outBlock(outBlock),
		.outValid(outValid),
		.outReady(outReady)
	);

endmodule

//--- sparseClusterPackerTb.sv
`timescale 1ns/10ps

module sparseClusterPackerTb import packerPkg::*; ();

	// Blocks per test
	localparam int ALL_ONES_BLOCKS = 20;
	localparam int RANDOM_BLOCKS = 200;
	localparam int MIXED_BLOCKS = 60;
	localparam int GAP_BLOCKS = 150;
	localparam int TOTAL_BLOCKS = ALL_ONES_BLOCKS + RANDOM_BLOCKS + MIXED_BLOCKS + GAP_BLOCKS;
	localparam int CYCLE_LIMIT = TOTAL_BLOCKS * 4 + 100;

	// Mask kinds for generated blocks
	localparam int MASK_ALL_ONES = 0;
	localparam int MASK_RANDOM = 1;
	localparam int MASK_ZERO = 2;

	logic clock = 1'b0;
	logic rstN;
	transferBlockT inBlock;
	logic inValid;
	logic inReady;
	macBlockT outBlock;
	logic outValid;
	logic outReady;

	integer seed = 32'h5c79;
	logic readyGaps = 1'b0;
	int cycleCount = 0;
	int acceptedInputs = 0;
	int selectedClusters = 0;
	int receivedBlocks = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int failsBefore = 0;

	sparseClusterPacker UUT (
		.clock(clock),
		.rstN(rstN),
		.inBlock(inBlock),
		.inValid(inValid),
		.inReady(inReady),
		.outBlock(outBlock),
		.outValid(outValid),
		.outReady(outReady)
	);

	always #5 clock = ~clock;

	// ==================================================
	// Transfer counters and timeout
	// ==================================================

	always @(posedge clock) begin
		if (rstN && inValid && inReady) begin
			acceptedInputs <= acceptedInputs + 1;
			selectedClusters <= selectedClusters + $countones(inBlock.selectMask);
		end
		if (rstN && outValid && outReady) begin
			receivedBlocks <= receivedBlocks + 1;
		end
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the packer stopped moving data", cycleCount);
			$display("Checks failed");
			$finish;
		end
	end

	// ==================================================
	// Stimulus helpers
	// ==================================================

	task automatic makeBlock(input int maskMode, output transferBlockT block);
		for (int lane = 0; lane < TRANSFER_SIZE; lane++) begin
			block.clusters[lane] = clusterT'($random(seed));
		end
		if (maskMode == MASK_ALL_ONES) begin
			block.selectMask = '1;
		end else if (maskMode == MASK_RANDOM) begin
			block.selectMask = TRANSFER_SIZE'($random(seed));
		end else begin
			block.selectMask = '0;
		end
	endtask

	// One clock edge, with a fresh outReady when gaps are on
	task automatic advanceCycle();
		@(posedge clock);
		if (readyGaps) begin
			outReady <= ($random(seed) % 2) == 0;
		end else begin
			outReady <= 1'b1;
		end
	endtask

	task automatic sendBlock(input transferBlockT block);
		inBlock <= block;
		inValid <= 1'b1;
		do begin
			advanceCycle();
		end while (!inReady);
	endtask

	task automatic idleCycle();
		inValid <= 1'b0;
		advanceCycle();
	endtask

	// Wait until both pipeline registers are empty
	task automatic drainPipeline();
		inValid <= 1'b0;
		do begin
			advanceCycle();
		end while (outValid || UUT.compValid);
		readyGaps = 1'b0;
		outReady <= 1'b1;
	endtask

	task automatic checkResetState(output int errors);
		errors = 0;
		@(negedge clock);
		if (outValid !== 1'b0) begin
			$display("** Error at %0t: outValid = %b, expected 0", $time, outValid);
			errors++;
		end
		if (inReady !== 1'b1) begin
			$display("** Error at %0t: inReady = %b, expected 1", $time, inReady);
			errors++;
		end
	endtask

	task automatic finishTest(input string name, input int extraErrors);
		int expectedBlocks;
		int newFails;

		@(negedge clock);
		expectedBlocks = selectedClusters / TRANSFER_SIZE;
		newFails = UUT.packerChecks.failCount - failsBefore;
		failsBefore = UUT.packerChecks.failCount;
		if (receivedBlocks != expectedBlocks) begin
			$display("** Error at %0t: receivedBlocks = %0d, expected %0d",
				$time, receivedBlocks, expectedBlocks);
		end
		if (receivedBlocks == expectedBlocks && newFails == 0 && extraErrors == 0) begin
			testsPassed++;
			$display("Test %0s passed, %0d blocks out so far", name, receivedBlocks);
		end else begin
			testsFailed++;
			$display("Test %0s failed with %0d assertion failures", name, newFails);
		end
		advanceCycle();
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		transferBlockT block;
		int resetErrors;

		rstN = 1'b0;
		inValid = 1'b0;
		inBlock = '0;
		outReady = 1'b1;

		repeat (10) @(posedge clock);
		rstN <= 1'b1;
		advanceCycle();
		checkResetState(resetErrors);
		finishTest("reset state", resetErrors);

		// Dense blocks pass through unchanged
		for (int i = 0; i < ALL_ONES_BLOCKS; i++) begin
			makeBlock(MASK_ALL_ONES, block);
			sendBlock(block);
		end
		drainPipeline();
		finishTest("all-ones masks", 0);

		for (int i = 0; i < RANDOM_BLOCKS; i++) begin
			makeBlock(MASK_RANDOM, block);
			sendBlock(block);
		end
		drainPipeline();
		finishTest("random masks", 0);

		// Every third block selects nothing
		for (int i = 0; i < MIXED_BLOCKS; i++) begin
			makeBlock((i % 3 == 2) ? MASK_ZERO : MASK_RANDOM, block);
			sendBlock(block);
		end
		drainPipeline();
		finishTest("zero masks mixed in", 0);

		readyGaps = 1'b1;
		for (int i = 0; i < GAP_BLOCKS; i++) begin
			if ($random(seed) % 4 == 0) begin
				idleCycle();
			end
			makeBlock(MASK_RANDOM, block);
			sendBlock(block);
		end
		drainPipeline();
		finishTest("outReady gaps", 0);

		$display("Tests passed %0d, failed %0d, inputs %0d, clusters %0d, blocks %0d",
			testsPassed, testsFailed, acceptedInputs, selectedClusters, receivedBlocks);
		if (testsFailed == 0 && UUT.packerChecks.failCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- sparseClusterPacker_assertions.sv
`timescale 1ns/10ps

module sparseClusterPacker_assertions import packerPkg::*; (
	input logic clock,
	input logic rstN,
	input transferBlockT inBlock,
	input logic inValid,
	input logic inReady,
	input logic compReady,
	input macBlockT outBlock,
	input logic outValid,
	input logic outReady
);

	// Selected clusters still waiting for the output in stream order
	clusterT modelQueue[$];
	macBlockT headBlock;
	logic headAvailable;

	// Clusters past the last full block as counted on the input side
	int streamFill;
	logic inTransfer;
	logic outTransfer;
	logic completesBlock;
	logic completedLast;

	// Stage 1 occupancy rebuilt from the top-level handshakes
	logic stageOneFull;

	int outputFails = 0;
	int holdFails = 0;
	int resetFails = 0;
	int latencyFails = 0;
	int readyFails = 0;
	int failCount;

	assign failCount = outputFails + holdFails + resetFails + latencyFails + readyFails;

	assign inTransfer = inValid && inReady;
	assign outTransfer = outValid && outReady;
	assign completesBlock = inTransfer
		&& (streamFill + $countones(inBlock.selectMask) >= TRANSFER_SIZE);

	// ==================================================
	// Reference stream model
	// ==================================================

	always @(posedge clock) begin
		if (!rstN) begin
			modelQueue.delete();
			streamFill <= 0;
			completedLast <= 1'b0;
			headAvailable <= 1'b0;
			headBlock <= '0;
			stageOneFull <= 1'b0;
		end else begin
			// Output side goes first since its clusters are older than the input's
			if (outTransfer) begin
				for (int slot = 0; slot < TRANSFER_SIZE; slot++) begin
					if (modelQueue.size() > 0) begin
						void'(modelQueue.pop_front());
					end
				end
			end
			if (inTransfer) begin
				for (int lane = 0; lane < TRANSFER_SIZE; lane++) begin
					if (inBlock.selectMask[lane]) begin
						modelQueue.push_back(inBlock.clusters[lane]);
					end
				end
				streamFill <= (streamFill + $countones(inBlock.selectMask)) % TRANSFER_SIZE;
			end
			// An item leaves stage 1 whenever stage 2 has room
			if (inTransfer) begin
				stageOneFull <= 1'b1;
			end else if (!outValid || outReady) begin
				stageOneFull <= 1'b0;
			end
			completedLast <= completesBlock;
			for (int slot = 0; slot < TRANSFER_SIZE; slot++) begin
				if (slot < modelQueue.size()) begin
					headBlock[slot] <= modelQueue[slot];
				end else begin
					headBlock[slot] <= '0;
				end
			end
			headAvailable <= modelQueue.size() >= TRANSFER_SIZE;
		end
	end

	// ==================================================
	// Concurrent checks
	// ==================================================

	outputMatchesModel: assert property (@(posedge clock) disable iff (!rstN)
		outTransfer |-> headAvailable && outBlock == headBlock)
		else begin
			outputFails++;
			$error("** Error at %0t: outBlock = %h, expected %h", $time, outBlock, headBlock);
		end

	outputHoldsUnderBackPressure: assert property (@(posedge clock) disable iff (!rstN)
		outValid && !outReady |=> outValid && $stable(outBlock))
		else begin
			holdFails++;
			$error("outBlock or outValid changed while outReady was low at %0t", $time);
		end

	outValidLowAfterReset: assert property (@(posedge clock)
		!rstN |=> !outValid)
		else begin
			resetFails++;
			$error("** Error at %0t: outValid = %b, expected 0 after reset", $time, outValid);
		end

	// A block-completing input reaches the output two cycles after acceptance
	blockLatencyTwoCycles: assert property (@(posedge clock) disable iff (!rstN)
		completedLast && compReady |=> outValid)
		else begin
			latencyFails++;
			$error("outValid did not rise two cycles after a block-completing input at %0t", $time);
		end

	inReadyLowOnlyWhenFull: assert property (@(posedge clock) disable iff (!rstN)
		!inReady |-> stageOneFull && outValid && !outReady)
		else begin
			readyFails++;
			$error("inReady was low while a pipeline stage had room at %0t", $time);
		end

endmodule

bind sparseClusterPacker sparseClusterPacker_assertions packerChecks (
	.clock(clock),
	.rstN(rstN),
	.inBlock(inBlock),
	.inValid(inValid),
	.inReady(inReady),
	.compReady(compReady),
	.outBlock(outBlock),
	.outValid(outValid),
	.outReady(outReady)
);

//--- tb.f
packerPkg.sv
maskAccumulator.sv
clusterCompactor.sv
residualBuffer.sv
sparseClusterPacker.sv
sparseClusterPacker_assertions.sv
sparseClusterPackerTb.sv
